// ==== afifo.f ====
hw/afifo_pkg.sv
hw/afifo_dpram.sv
hw/afifo_wr_ctrl.sv
hw/afifo_rd_ctrl.sv
hw/afifo_top.sv
sim/afifo_tb.sv

// ==== hw/afifo_dpram.sv ====
module afifo_dpram #(
  parameter int DATA_WIDTH = afifo_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = afifo_pkg::DEF_ADDR_WIDTH
) (
  input  logic                  wr_clk,
  input  logic                  wr_we,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_re,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // --------------------
  // Write port
  // --------------------

  always_ff @(posedge wr_clk) begin
    if (wr_we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // --------------------
  // Read port
  // --------------------

  // The read controller only addresses words whose write is already visible
  // on its side, so a read never collides with a write to the same entry
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_re) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== hw/afifo_pkg.sv ====
package afifo_pkg;

  // The default FIFO holds 16 words of 8 bits
  localparam int DEF_DATA_WIDTH = 8;
  localparam int DEF_ADDR_WIDTH = 4;

  // Widest pointer the conversion functions handle
  localparam int MAX_PTR_WIDTH = 32;

  // --------------------
  // Gray code conversion
  // --------------------

  // Callers pass a zero-extended pointer, so the upper bits stay zero
  function automatic logic [MAX_PTR_WIDTH-1:0] bin2gray(
    input logic [MAX_PTR_WIDTH-1:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at or above it
  function automatic logic [MAX_PTR_WIDTH-1:0] gray2bin(
    input logic [MAX_PTR_WIDTH-1:0] gray
  );
    logic [MAX_PTR_WIDTH-1:0] bin;
    bin[MAX_PTR_WIDTH-1] = gray[MAX_PTR_WIDTH-1];
    for (int i = MAX_PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== hw/afifo_rd_ctrl.sv ====
module afifo_rd_ctrl #(
  parameter int ADDR_WIDTH   = afifo_pkg::DEF_ADDR_WIDTH,
  parameter int AEMPTY_LEVEL = 2
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH:0]   wr_ptr_gray,
  output logic [ADDR_WIDTH:0]   rd_ptr_gray,
  output logic [ADDR_WIDTH-1:0] rd_addr,
  output logic                  rd_re,
  output logic                  empty,
  output logic                  aempty
);

  import afifo_pkg::*;

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam int PTR_W = ADDR_WIDTH + 1;

  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] rd_ptr_nxt;
  logic [ADDR_WIDTH:0] rd_ptr_gray_nxt;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync2;
  logic [ADDR_WIDTH:0] wr_ptr_sync_bin;
  logic [ADDR_WIDTH:0] fill_nxt;

  // --------------------
  // Read pointer
  // --------------------

  assign rd_re           = rd_en & ~empty;
  assign rd_ptr_nxt      = rd_ptr + {{ADDR_WIDTH{1'b0}}, rd_re};
  assign rd_ptr_gray_nxt = PTR_W'(bin2gray(MAX_PTR_WIDTH'(rd_ptr_nxt)));
  assign rd_addr         = rd_ptr[ADDR_WIDTH-1:0];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_ptr_gray_nxt;
    end
  end

  // --------------------
  // Write pointer crossing
  // --------------------

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_ptr_gray_sync1 <= '0;
      wr_ptr_gray_sync2 <= '0;
    end else begin
      wr_ptr_gray_sync1 <= wr_ptr_gray;
      wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
    end
  end

  assign wr_ptr_sync_bin = PTR_W'(gray2bin(MAX_PTR_WIDTH'(wr_ptr_gray_sync2)));

  // --------------------
  // Flags
  // --------------------

  // A lagging write pointer makes the read side see fewer words than exist
  assign fill_nxt = wr_ptr_sync_bin - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_ptr_nxt == wr_ptr_sync_bin);
      aempty <= (fill_nxt <= PTR_W'(AEMPTY_LEVEL));
    end
  end

  // --------------------
  // Assertions
  // --------------------

  // A FIFO that is empty by the pointers seen here must hold the read pointer
  a_no_advance_when_empty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    (rd_ptr == wr_ptr_sync_bin) |=> $stable(rd_ptr)
  ) else $error("read pointer moved while empty");

  // Breaks if the write side ever overruns entries not yet read
  a_rd_fill_in_range: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    fill_nxt <= PTR_W'(DEPTH)
  ) else $error("read-side fill %0d exceeds depth", fill_nxt);

endmodule

// ==== hw/afifo_top.sv ====
module afifo_top #(
  parameter int DATA_WIDTH   = afifo_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH   = afifo_pkg::DEF_ADDR_WIDTH,
  parameter int AFULL_LEVEL  = (2 ** ADDR_WIDTH) - 2,
  parameter int AEMPTY_LEVEL = 2
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  empty,
  output logic                  afull,
  output logic                  aempty
);

  // Gray pointers cross between the two clock domains
  logic [ADDR_WIDTH:0]   wr_ptr_gray;
  logic [ADDR_WIDTH:0]   rd_ptr_gray;

  // RAM port controls
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic                  wr_we;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic                  rd_re;

  // --------------------
  // Write domain
  // --------------------

  afifo_wr_ctrl #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .AFULL_LEVEL (AFULL_LEVEL)
  ) u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_ptr_gray (wr_ptr_gray),
    .wr_addr     (wr_addr),
    .wr_we       (wr_we),
    .full        (full),
    .afull       (afull)
  );

  // --------------------
  // Read domain
  // --------------------

  afifo_rd_ctrl #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) u_rd_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_ptr_gray  (wr_ptr_gray),
    .rd_ptr_gray  (rd_ptr_gray),
    .rd_addr      (rd_addr),
    .rd_re        (rd_re),
    .empty        (empty),
    .aempty       (aempty)
  );

  // --------------------
  // Storage
  // --------------------

  afifo_dpram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_dpram (
    .wr_clk     (wr_clk),
    .wr_we      (wr_we),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .rd_re      (rd_re),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

endmodule

// ==== hw/afifo_wr_ctrl.sv ====
module afifo_wr_ctrl #(
  parameter int ADDR_WIDTH  = afifo_pkg::DEF_ADDR_WIDTH,
  parameter int AFULL_LEVEL = (2 ** ADDR_WIDTH) - 2
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH:0]   rd_ptr_gray,
  output logic [ADDR_WIDTH:0]   wr_ptr_gray,
  output logic [ADDR_WIDTH-1:0] wr_addr,
  output logic                  wr_we,
  output logic                  full,
  output logic                  afull
);

  import afifo_pkg::*;

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam int PTR_W = ADDR_WIDTH + 1;

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_nxt;
  logic [ADDR_WIDTH:0] wr_ptr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync2;
  logic [ADDR_WIDTH:0] rd_ptr_sync_bin;
  logic [ADDR_WIDTH:0] fill_nxt;

  // --------------------
  // Write pointer
  // --------------------

  assign wr_we           = wr_en & ~full;
  assign wr_ptr_nxt      = wr_ptr + {{ADDR_WIDTH{1'b0}}, wr_we};
  assign wr_ptr_gray_nxt = PTR_W'(bin2gray(MAX_PTR_WIDTH'(wr_ptr_nxt)));
  assign wr_addr         = wr_ptr[ADDR_WIDTH-1:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_ptr_gray_nxt;
    end
  end

  // --------------------
  // Read pointer crossing
  // --------------------

  // Only one bit of the Gray pointer moves per read, so a sample taken
  // mid-change resolves to either the old or the new position
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_ptr_gray_sync1 <= '0;
      rd_ptr_gray_sync2 <= '0;
    end else begin
      rd_ptr_gray_sync1 <= rd_ptr_gray;
      rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
    end
  end

  assign rd_ptr_sync_bin = PTR_W'(gray2bin(MAX_PTR_WIDTH'(rd_ptr_gray_sync2)));

  // --------------------
  // Flags
  // --------------------

  // The read pointer seen here lags, so the fill is never underestimated
  assign fill_nxt = wr_ptr_nxt - rd_ptr_sync_bin;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (fill_nxt == PTR_W'(DEPTH));
      afull <= (fill_nxt >= PTR_W'(AFULL_LEVEL));
    end
  end

  // --------------------
  // Assertions
  // --------------------

  // A FIFO that is full by the pointers seen here must hold the write pointer
  a_no_advance_when_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    (PTR_W'(wr_ptr - rd_ptr_sync_bin) == PTR_W'(DEPTH)) |=> $stable(wr_ptr)
  ) else $error("write pointer moved while full");

  // Holds only if the read side never passes a write it has not seen
  a_wr_fill_in_range: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    fill_nxt <= PTR_W'(DEPTH)
  ) else $error("write-side fill %0d exceeds depth", fill_nxt);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the afifo testbench with Verilator, runs it and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=afifo_tb

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found on PATH"
  exit 1
fi

echo "Building $TOP"
verilator --binary --timing --assert -j 0 \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -f afifo.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

echo "Running $TOP"
"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail, see $LOG"
  exit 1
fi

// ==== sim/afifo_tb.sv ====
module afifo_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import afifo_pkg::*;

  localparam int DATA_WIDTH   = DEF_DATA_WIDTH;
  localparam int DEPTH        = 1 << DEF_ADDR_WIDTH;
  localparam int AFULL_LEVEL  = DEPTH - 2;
  localparam int AEMPTY_LEVEL = 2;
  localparam int FILL_CYCLES  = 60;
  localparam int DRAIN_CYCLES = 60;
  localparam int MIXED_CYCLES = 1500;
  // The phases need about 1700 rd_clk cycles, so this leaves ample margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int MODEL_AW     = 12;
  localparam logic [31:0] SEED = 32'h7ef2c5c4;

  logic                  wr_clk = 1'b0;
  logic                  rd_clk = 1'b0;
  logic                  wr_rst_n = 1'b0;
  logic                  rd_rst_n = 1'b0;
  logic                  wr_en = 1'b0;
  logic                  rd_en = 1'b0;
  logic [DATA_WIDTH-1:0] wr_data = '0;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  full;
  logic                  empty;
  logic                  afull;
  logic                  aempty;

  // The reference model is a circular queue indexed by the accepted word counts
  logic [DATA_WIDTH-1:0] exp_mem [2**MODEL_AW];
  logic [DATA_WIDTH-1:0] exp_rd_data;
  int                    wr_count;
  int                    rd_count;
  int                    wr_idle_edges;
  int                    rd_idle_edges;
  int                    true_fill;
  int                    wr_errors;
  int                    rd_errors;
  int                    end_errors;
  logic [31:0]           wr_lfsr = SEED;
  logic [31:0]           rd_lfsr = SEED;
  logic                  mixed_done;

  afifo_top u_afifo_top (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  initial begin
    forever #7 wr_clk = ~wr_clk;
  end

  initial begin
    forever #10 rd_clk = ~rd_clk;
  end

  // --------------------
  // Helpers
  // --------------------

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Three bits give a write chance of 3 in 8 that stays close to the read rate
  task automatic draw_wr_en();
    logic [2:0] pick;
    for (int i = 0; i < 3; i++) begin
      wr_lfsr = lfsr_next(wr_lfsr);
      pick[i] = wr_lfsr[0];
    end
    wr_en = (pick < 3'd3);
  endtask

  task automatic draw_rd_en();
    rd_lfsr = lfsr_next(rd_lfsr);
    rd_en = rd_lfsr[0];
  endtask

  task automatic report_wr_mismatch(input string name, input int got, input int expected);
    wr_errors++;
    $display("Error at %0d ns: %s = %0d, expected %0d", $time, name, got, expected);
  endtask

  task automatic report_rd_mismatch(input string name, input int got, input int expected);
    rd_errors++;
    $display("Error at %0d ns: %s = %0d, expected %0d", $time, name, got, expected);
  endtask

  // --------------------
  // Reference model
  // --------------------

  assign true_fill = wr_count - rd_count;

  always @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_count      <= 0;
      wr_idle_edges <= 0;
    end else if (wr_en && !full) begin
      exp_mem[wr_count[MODEL_AW-1:0]] <= wr_data;
      wr_count      <= wr_count + 1;
      wr_idle_edges <= 0;
    end else begin
      wr_idle_edges <= wr_idle_edges + 1;
    end
  end

  always @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_count      <= 0;
      rd_idle_edges <= 0;
      exp_rd_data   <= '0;
    end else if (rd_en && !empty) begin
      exp_rd_data   <= exp_mem[rd_count[MODEL_AW-1:0]];
      rd_count      <= rd_count + 1;
      rd_idle_edges <= 0;
    end else begin
      rd_idle_edges <= rd_idle_edges + 1;
    end
  end

  // --------------------
  // Checks
  // --------------------

  a_full_after_reset: assert property (@(posedge wr_clk) $rose(wr_rst_n) |-> !full)
    else report_wr_mismatch("full", int'($sampled(full)), 0);
  a_afull_after_reset: assert property (@(posedge wr_clk) $rose(wr_rst_n) |-> !afull)
    else report_wr_mismatch("afull", int'($sampled(afull)), 0);
  a_empty_after_reset: assert property (@(posedge rd_clk) $rose(rd_rst_n) |-> empty)
    else report_rd_mismatch("empty", int'($sampled(empty)), 1);
  a_aempty_after_reset: assert property (@(posedge rd_clk) $rose(rd_rst_n) |-> aempty)
    else report_rd_mismatch("aempty", int'($sampled(aempty)), 1);

  a_rd_data: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) rd_data == exp_rd_data
  ) else report_rd_mismatch("rd_data", int'($sampled(rd_data)), int'($sampled(exp_rd_data)));

  a_full_at_depth: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) (true_fill == DEPTH) |-> full
  ) else report_wr_mismatch("full", int'($sampled(full)), 1);

  a_afull_at_level: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) (true_fill >= AFULL_LEVEL) |-> afull
  ) else report_wr_mismatch("afull", int'($sampled(afull)), 1);

  a_empty_at_zero: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) (true_fill == 0) |-> empty
  ) else report_rd_mismatch("empty", int'($sampled(empty)), 1);

  a_aempty_at_level: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) (true_fill <= AEMPTY_LEVEL) |-> aempty
  ) else report_rd_mismatch("aempty", int'($sampled(aempty)), 1);

  // Three idle rd_clk edges span more than the four wr_clk edges a read needs
  a_full_clears: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    (rd_idle_edges >= 3 && true_fill < DEPTH) |-> !full
  ) else report_wr_mismatch("full", int'($sampled(full)), 0);

  a_afull_clears: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    (rd_idle_edges >= 3 && true_fill < AFULL_LEVEL) |-> !afull
  ) else report_wr_mismatch("afull", int'($sampled(afull)), 0);

  // Six idle wr_clk edges span more than the four rd_clk edges a write needs
  a_empty_clears: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    (wr_idle_edges >= 6 && true_fill != 0) |-> !empty
  ) else report_rd_mismatch("empty", int'($sampled(empty)), 0);

  a_aempty_clears: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    (wr_idle_edges >= 6 && true_fill > AEMPTY_LEVEL) |-> !aempty
  ) else report_rd_mismatch("aempty", int'($sampled(aempty)), 0);

  // --------------------
  // Stimulus
  // --------------------

  initial begin
    mixed_done = 1'b0;
    end_errors = 0;
    repeat (3) @(negedge rd_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;

    // Fill well past full so that writes are tried while full
    repeat (FILL_CYCLES) begin
      @(negedge wr_clk);
      wr_en   = 1'b1;
      wr_data = wr_data + DATA_WIDTH'(1);
    end
    @(negedge wr_clk);
    wr_en = 1'b0;

    repeat (DRAIN_CYCLES) begin
      @(negedge rd_clk);
      rd_en = 1'b1;
    end

    fork
      begin
        repeat (MIXED_CYCLES) begin
          @(negedge rd_clk);
          draw_rd_en();
        end
        mixed_done = 1'b1;
      end
      begin
        while (!mixed_done) begin
          @(negedge wr_clk);
          draw_wr_en();
          wr_data = wr_data + DATA_WIDTH'(1);
        end
      end
    join
    @(negedge wr_clk);
    wr_en = 1'b0;

    // Drain what is left, then keep reading while empty
    while (rd_count != wr_count) begin
      @(negedge rd_clk);
      rd_en = 1'b1;
    end
    repeat (8) @(negedge rd_clk);
    rd_en = 1'b0;
    repeat (4) @(negedge rd_clk);

    assert (rd_count == wr_count) else begin
      end_errors++;
      $display("Error at %0d ns: rd_count = %0d, expected %0d", $time, rd_count, wr_count);
    end
    assert (wr_count >= 200) else begin
      end_errors++;
      $display("Only %0d words went through the FIFO, too few for the test", wr_count);
    end

    $display("Done: %0d words, %0d write-side errors, %0d read-side errors, %0d end errors",
             wr_count, wr_errors, rd_errors, end_errors);
    if (wr_errors + rd_errors + end_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge rd_clk);
      cycles++;
    end
    $display("Timeout after %0d rd_clk cycles, the test did not finish", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
